/* source/fsb_defs.svh */
`ifndef FSB_DEFS_SVH
`define FSB_DEFS_SVH

// Word and address geometry of each bank.
`define FSB_DATA_W 16
`define FSB_ADDR_W 15
`define FSB_DEPTH 24200

// Window walk geometry.
`define FSB_LANES 3
`define FSB_CHANNELS 2
`define FSB_LANE_STRIDE 2
`define FSB_WINDOW_STRIDE 6
`define FSB_NUM_WINDOWS 1444

`endif

/* source/fsb_data_pkg.sv */
`include "fsb_defs.svh"

package fsb_data_pkg;

	// One feature word as held in either bank.
	typedef logic [`FSB_DATA_W-1:0] feature_t;

	// Word address within one bank.
	typedef logic [`FSB_ADDR_W-1:0] buf_addr_t;

endpackage

/* source/fsb_ctrl_pkg.sv */
package fsb_ctrl_pkg;

	typedef enum logic {
		WB_IDLE,
		WB_ACK
	} wb_state_t;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_RUN,
		SEQ_DRAIN
	} seq_state_t;

	// Encoding matches the eltwise select pin.
	typedef enum logic {
		SRC_POOL = 1'b0,
		SRC_ELTWISE = 1'b1
	} bank1_src_t;

endpackage

/* source/fsb_ifaces.sv */
`timescale 1ns/10ps

interface bank_write_if;
	import fsb_data_pkg::*;

	logic wen0;
	buf_addr_t waddr0;
	feature_t wdata0;
	logic wen1;
	buf_addr_t waddr1;
	feature_t wdata1;

	modport producer (
		output wen0,
		output waddr0,
		output wdata0,
		output wen1,
		output waddr1,
		output wdata1
	);

	modport buffer (
		input wen0,
		input waddr0,
		input wdata0,
		input wen1,
		input waddr1,
		input wdata1
	);
endinterface

interface bank_read_if;
	import fsb_data_pkg::*;

	logic rd_en;
	buf_addr_t raddr;
	// Both banks answer the same address.
	feature_t rdata0;
	feature_t rdata1;

	modport consumer (
		output rd_en,
		output raddr,
		input rdata0,
		input rdata1
	);

	modport buffer (
		input rd_en,
		input raddr,
		output rdata0,
		output rdata1
	);
endinterface

/* source/feature_write_port.sv */
`timescale 1ns/10ps

module feature_write_port (
	input logic clk,
	input logic i_reset,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_we,
	input fsb_data_pkg::buf_addr_t i_wb_adr,
	input fsb_data_pkg::feature_t i_wb_dat,
	output logic o_wb_ack,
	input logic i_wen1,
	input fsb_data_pkg::buf_addr_t i_waddr1,
	input fsb_data_pkg::feature_t i_pool,
	input fsb_data_pkg::feature_t i_eltwise,
	input logic i_eltwise_sel,
	bank_write_if.producer wr
);
	import fsb_data_pkg::*;
	import fsb_ctrl_pkg::*;

	wb_state_t wb_state;
	bank1_src_t src;
	feature_t src_data;
	logic wen1_q;
	buf_addr_t waddr1_q;
	feature_t wdata1_q;

	// Single cycle ack, then back to idle.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			wb_state <= WB_IDLE;
		end else begin
			case (wb_state)
				WB_IDLE: begin
					if (i_wb_cyc && i_wb_stb) begin
						wb_state <= WB_ACK;
					end
				end
				default: begin
					wb_state <= WB_IDLE;
				end
			endcase
		end
	end

	assign o_wb_ack = (wb_state == WB_ACK);

	// Master holds address and data until ack.
	assign wr.wen0 = o_wb_ack && i_wb_cyc && i_wb_stb && i_wb_we;
	assign wr.waddr0 = i_wb_adr;
	assign wr.wdata0 = i_wb_dat;

	assign src = bank1_src_t'(i_eltwise_sel);

	always_comb begin
		case (src)
			SRC_ELTWISE: src_data = i_eltwise;
			default: src_data = i_pool;
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			wen1_q <= 1'b0;
		end else begin
			wen1_q <= i_wen1;
		end
	end

	always_ff @(posedge clk) begin
		waddr1_q <= i_waddr1;
		wdata1_q <= src_data;
	end

	assign wr.wen1 = wen1_q;
	assign wr.waddr1 = waddr1_q;
	assign wr.wdata1 = wdata1_q;
endmodule

/* source/feature_bank_ram.sv */
`timescale 1ns/10ps
`include "fsb_defs.svh"

module feature_bank_ram #(
	parameter int DATA_W = 16,
	parameter int ADDR_W = 15
) (
	input logic clk,
	input logic i_wen,
	input logic [ADDR_W-1:0] i_waddr,
	input logic [DATA_W-1:0] i_wdata,
	input logic [ADDR_W-1:0] i_raddr,
	output logic [DATA_W-1:0] o_rdata
);
	logic [DATA_W-1:0] mem [0:`FSB_DEPTH-1];
	logic [ADDR_W-1:0] raddr_q;
	logic [DATA_W-1:0] rdata_q;
	logic [DATA_W-1:0] pipe_q;

	always_ff @(posedge clk) begin
		if (i_wen) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// Address, array and output stage make three cycles.
	always_ff @(posedge clk) begin
		raddr_q <= i_raddr;
		rdata_q <= mem[raddr_q];
		pipe_q <= rdata_q;
	end

	assign o_rdata = pipe_q;
endmodule

/* source/dual_bank_feature_buffer.sv */
`timescale 1ns/10ps
`include "fsb_defs.svh"

module dual_bank_feature_buffer (
	input logic clk,
	bank_write_if.buffer wr,
	bank_read_if.buffer rd
);
	import fsb_data_pkg::*;

	buf_addr_t hold_addr;
	buf_addr_t bank_raddr;

	// Last walk address is replayed while idle.
	always_ff @(posedge clk) begin
		if (rd.rd_en) begin
			hold_addr <= rd.raddr;
		end
	end

	assign bank_raddr = rd.rd_en ? rd.raddr : hold_addr;

	feature_bank_ram #(
		.DATA_W(`FSB_DATA_W),
		.ADDR_W(`FSB_ADDR_W)
	) bank0 (
		.clk(clk),
		.i_wen(wr.wen0),
		.i_waddr(wr.waddr0),
		.i_wdata(wr.wdata0),
		.i_raddr(bank_raddr),
		.o_rdata(rd.rdata0)
	);

	// Pooled or eltwise results.
	feature_bank_ram #(
		.DATA_W(`FSB_DATA_W),
		.ADDR_W(`FSB_ADDR_W)
	) bank1 (
		.clk(clk),
		.i_wen(wr.wen1),
		.i_waddr(wr.waddr1),
		.i_wdata(wr.wdata1),
		.i_raddr(bank_raddr),
		.o_rdata(rd.rdata1)
	);
endmodule

/* source/window_read_sequencer.sv */
`timescale 1ns/10ps
`include "fsb_defs.svh"

module window_read_sequencer #(
	parameter int NUM_WINDOWS = `FSB_NUM_WINDOWS
) (
	input logic clk,
	input logic i_reset,
	input logic i_start,
	bank_read_if.consumer rd,
	output logic o_valid,
	output logic o_done
);
	import fsb_data_pkg::*;
	import fsb_ctrl_pkg::*;

	localparam int LANE_W = (`FSB_LANES > 1) ? $clog2(`FSB_LANES) : 1;
	localparam int CHAN_W = (`FSB_CHANNELS > 1) ? $clog2(`FSB_CHANNELS) : 1;
	localparam int WIN_W = (NUM_WINDOWS > 1) ? $clog2(NUM_WINDOWS) : 1;
	// Base has already moved one per channel inside the window.
	localparam buf_addr_t WIN_STEP = buf_addr_t'(`FSB_WINDOW_STRIDE - `FSB_CHANNELS + 1);
	localparam buf_addr_t LANE_STEP = buf_addr_t'(`FSB_LANE_STRIDE);

	seq_state_t state;
	logic [LANE_W-1:0] lane;
	logic [CHAN_W-1:0] chan;
	logic [WIN_W-1:0] win;
	buf_addr_t base;
	buf_addr_t offset;
	logic run;
	logic lane_last;
	logic chan_last;
	logic win_last;
	logic walk_end;
	logic [2:0] vld_sr;
	logic [2:0] last_sr;

	assign run = (state == SEQ_RUN);
	assign lane_last = (lane == LANE_W'(`FSB_LANES - 1));
	assign chan_last = (chan == CHAN_W'(`FSB_CHANNELS - 1));
	assign win_last = (win == WIN_W'(NUM_WINDOWS - 1));
	assign walk_end = run && lane_last && chan_last && win_last;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state <= SEQ_IDLE;
			lane <= '0;
			chan <= '0;
			win <= '0;
			base <= '0;
			offset <= '0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (i_start) begin
						state <= SEQ_RUN;
					end
				end
				SEQ_RUN: begin
					if (walk_end) begin
						state <= SEQ_DRAIN;
						lane <= '0;
						chan <= '0;
						win <= '0;
						base <= '0;
						offset <= '0;
					end else if (lane_last && chan_last) begin
						win <= win + 1'b1;
						chan <= '0;
						lane <= '0;
						base <= base + WIN_STEP;
						offset <= '0;
					end else if (lane_last) begin
						chan <= chan + 1'b1;
						lane <= '0;
						base <= base + buf_addr_t'(1);
						offset <= '0;
					end else begin
						lane <= lane + 1'b1;
						offset <= offset + LANE_STEP;
					end
				end
				SEQ_DRAIN: begin
					// Idle once the last word is out.
					if (last_sr[2]) begin
						state <= SEQ_IDLE;
					end
				end
				default: begin
					state <= SEQ_IDLE;
				end
			endcase
		end
	end

	assign rd.rd_en = run;
	assign rd.raddr = base + offset;

	// Flags follow the bank read latency.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			vld_sr <= '0;
			last_sr <= '0;
		end else begin
			vld_sr <= {vld_sr[1:0], run};
			last_sr <= {last_sr[1:0], walk_end};
		end
	end

	assign o_valid = vld_sr[2];
	assign o_done = last_sr[2];
endmodule

/* source/feature_stream_buffer.sv */
`timescale 1ns/10ps
`include "fsb_defs.svh"

module feature_stream_buffer #(
	parameter int NUM_WINDOWS = `FSB_NUM_WINDOWS
) (
	input logic clk,
	input logic i_reset,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_we,
	input fsb_data_pkg::buf_addr_t i_wb_adr,
	input fsb_data_pkg::feature_t i_wb_dat,
	output logic o_wb_ack,
	input logic i_wen1,
	input fsb_data_pkg::buf_addr_t i_waddr1,
	input fsb_data_pkg::feature_t i_pool,
	input fsb_data_pkg::feature_t i_eltwise,
	input logic i_eltwise_sel,
	input logic i_start,
	output fsb_data_pkg::feature_t o_feature_0,
	output fsb_data_pkg::feature_t o_feature_1,
	output logic o_valid,
	output logic o_done
);
	bank_write_if wr_if ();
	bank_read_if rd_if ();

	feature_write_port u_write_port (
		.clk(clk),
		.i_reset(i_reset),
		.i_wb_cyc(i_wb_cyc),
		.i_wb_stb(i_wb_stb),
		.i_wb_we(i_wb_we),
		.i_wb_adr(i_wb_adr),
		.i_wb_dat(i_wb_dat),
		.o_wb_ack(o_wb_ack),
		.i_wen1(i_wen1),
		.i_waddr1(i_waddr1),
		.i_pool(i_pool),
		.i_eltwise(i_eltwise),
		.i_eltwise_sel(i_eltwise_sel),
		.wr(wr_if.producer)
	);

	dual_bank_feature_buffer u_buffer (
		.clk(clk),
		.wr(wr_if.buffer),
		.rd(rd_if.buffer)
	);

	window_read_sequencer #(
		.NUM_WINDOWS(NUM_WINDOWS)
	) u_sequencer (
		.clk(clk),
		.i_reset(i_reset),
		.i_start(i_start),
		.rd(rd_if.consumer),
		.o_valid(o_valid),
		.o_done(o_done)
	);

	// Bank words leave side by side.
	assign o_feature_0 = rd_if.rdata0;
	assign o_feature_1 = rd_if.rdata1;
endmodule

/* sim/tb_feature_stream_buffer.sv */
`timescale 1ns/10ps
`include "fsb_defs.svh"

module tb_feature_stream_buffer;
	import fsb_data_pkg::*;

	localparam int NUM_WIN = 4;
	localparam int PERIOD = 20;
	localparam int WIN_WORDS = `FSB_LANES * `FSB_CHANNELS;
	localparam int WALK_WORDS = WIN_WORDS * NUM_WIN;
	localparam int FILL_WRITES = 2 * WALK_WORDS;
	localparam int WATCHDOG_CYCLES = FILL_WRITES + WIN_WORDS * NUM_WIN * 2 + 200;

	logic clk;
	logic i_reset;
	logic i_wb_cyc;
	logic i_wb_stb;
	logic i_wb_we;
	buf_addr_t i_wb_adr;
	feature_t i_wb_dat;
	logic o_wb_ack;
	logic i_wen1;
	buf_addr_t i_waddr1;
	feature_t i_pool;
	feature_t i_eltwise;
	logic i_eltwise_sel;
	logic i_start;
	feature_t o_feature_0;
	feature_t o_feature_1;
	logic o_valid;
	logic o_done;

	// Mirror of both banks, indexed by word address.
	feature_t model0 [0:WALK_WORDS-1];
	feature_t model1 [0:WALK_WORDS-1];
	feature_t exp0;
	feature_t exp1;
	logic exp_last;
	int word_count = 0;
	int done_count = 0;
	int ack_count = 0;
	int error_count = 0;
	integer seed;

	feature_stream_buffer #(
		.NUM_WINDOWS(NUM_WIN)
	) DUT (
		.clk(clk),
		.i_reset(i_reset),
		.i_wb_cyc(i_wb_cyc),
		.i_wb_stb(i_wb_stb),
		.i_wb_we(i_wb_we),
		.i_wb_adr(i_wb_adr),
		.i_wb_dat(i_wb_dat),
		.o_wb_ack(o_wb_ack),
		.i_wen1(i_wen1),
		.i_waddr1(i_waddr1),
		.i_pool(i_pool),
		.i_eltwise(i_eltwise),
		.i_eltwise_sel(i_eltwise_sel),
		.i_start(i_start),
		.o_feature_0(o_feature_0),
		.o_feature_1(o_feature_1),
		.o_valid(o_valid),
		.o_done(o_done)
	);

	always #(PERIOD / 2) clk = ~clk;

	// Lane innermost, then channel, then window.
	function automatic int walk_addr(input int k);
		int w;
		int c;
		int l;
		w = k / WIN_WORDS;
		c = (k / `FSB_LANES) % `FSB_CHANNELS;
		l = k % `FSB_LANES;
		return `FSB_WINDOW_STRIDE * w + c + `FSB_LANE_STRIDE * l;
	endfunction

	// Expected pair for the word that the next rising edge samples.
	always @(negedge clk) begin
		if (o_valid === 1'b1) begin
			exp0 = model0[walk_addr(word_count % WALK_WORDS)];
			exp1 = model1[walk_addr(word_count % WALK_WORDS)];
			exp_last = ((word_count % WALK_WORDS) == WALK_WORDS - 1);
			word_count = word_count + 1;
		end
		if (o_wb_ack === 1'b1) begin
			ack_count = ack_count + 1;
		end
		if (o_done === 1'b1) begin
			done_count = done_count + 1;
		end
	end

	reset_quiet: assert property (@(posedge clk)
		i_reset |=> ({o_wb_ack, o_valid, o_done} == 3'b000))
		else begin
			error_count++;
			$display("Error at %0t: {o_wb_ack, o_valid, o_done} = %b, expected 000",
				$time, $sampled({o_wb_ack, o_valid, o_done}));
		end

	ack_follows_req: assert property (@(posedge clk) disable iff (i_reset)
		(i_wb_cyc && i_wb_stb && !o_wb_ack) |=> o_wb_ack)
		else begin
			error_count++;
			$display("Error at %0t: o_wb_ack = %b, expected 1", $time, $sampled(o_wb_ack));
		end

	ack_one_cycle: assert property (@(posedge clk) disable iff (i_reset)
		o_wb_ack |=> !o_wb_ack)
		else begin
			error_count++;
			$display("Error at %0t: o_wb_ack = %b, expected 0", $time, $sampled(o_wb_ack));
		end

	feature0_match: assert property (@(posedge clk) disable iff (i_reset)
		o_valid |-> (o_feature_0 == exp0))
		else begin
			error_count++;
			$display("Error at %0t: o_feature_0 = %h, expected %h",
				$time, $sampled(o_feature_0), exp0);
		end

	feature1_match: assert property (@(posedge clk) disable iff (i_reset)
		o_valid |-> (o_feature_1 == exp1))
		else begin
			error_count++;
			$display("Error at %0t: o_feature_1 = %h, expected %h",
				$time, $sampled(o_feature_1), exp1);
		end

	done_on_last: assert property (@(posedge clk) disable iff (i_reset)
		o_valid |-> (o_done == exp_last))
		else begin
			error_count++;
			$display("Error at %0t: o_done = %b, expected %b", $time, $sampled(o_done), exp_last);
		end

	done_needs_valid: assert property (@(posedge clk) disable iff (i_reset)
		o_done |-> o_valid)
		else begin
			error_count++;
			$display("Error at %0t: o_valid = %b, expected 1", $time, $sampled(o_valid));
		end

	task automatic wishbone_cycle(input buf_addr_t addr, input feature_t data, input logic we);
		@(negedge clk);
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we = we;
		i_wb_adr = addr;
		i_wb_dat = data;
		@(negedge clk);
		while (o_wb_ack !== 1'b1) begin
			@(negedge clk);
		end
		// Hold through the ack edge, where the word lands.
		@(negedge clk);
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
		if (we) begin
			model0[addr] = data;
		end
	endtask

	task automatic write_bank1(input buf_addr_t addr, input feature_t pool,
		input feature_t eltwise, input logic sel);
		@(negedge clk);
		i_wen1 = 1'b1;
		i_waddr1 = addr;
		i_pool = pool;
		i_eltwise = eltwise;
		i_eltwise_sel = sel;
		model1[addr] = sel ? eltwise : pool;
	endtask

	task automatic start_walk();
		@(negedge clk);
		i_start = 1'b1;
		@(negedge clk);
		i_start = 1'b0;
	endtask

	task automatic wait_for_done();
		while (o_done !== 1'b1) begin
			@(negedge clk);
		end
	endtask

	task automatic check_pass(input int passes);
		repeat (8) @(negedge clk);
		@(posedge clk);
		assert (word_count == passes * WALK_WORDS)
			else begin
				error_count++;
				$display("Error at %0t: o_valid word count = %0d, expected %0d",
					$time, word_count, passes * WALK_WORDS);
			end
		assert (done_count == passes)
			else begin
				error_count++;
				$display("Error at %0t: o_done pulse count = %0d, expected %0d",
					$time, done_count, passes);
			end
	endtask

	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		$display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		int a;
		seed = 90;
		clk = 1'b0;
		i_reset = 1'b1;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
		i_wb_adr = '0;
		i_wb_dat = '0;
		i_wen1 = 1'b0;
		i_waddr1 = '0;
		i_pool = '0;
		i_eltwise = '0;
		i_eltwise_sel = 1'b0;
		i_start = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		i_reset = 1'b0;

		for (a = 0; a < WALK_WORDS; a++) begin
			wishbone_cycle(buf_addr_t'(a), feature_t'($random(seed)), 1'b1);
		end
		// An acked read cycle leaves bank 0 unchanged.
		wishbone_cycle(buf_addr_t'(5), feature_t'($random(seed)), 1'b0);

		// Select alternates so both sources are seen.
		for (a = 0; a < WALK_WORDS; a++) begin
			write_bank1(buf_addr_t'(a), feature_t'($random(seed)),
				feature_t'($random(seed)), 1'(a));
		end
		@(negedge clk);
		i_wen1 = 1'b0;

		// The first pass gets a second start mid-walk.
		start_walk();
		repeat (6) @(negedge clk);
		start_walk();
		wait_for_done();
		check_pass(1);

		for (a = 1; a < WALK_WORDS; a += 5) begin
			write_bank1(buf_addr_t'(a), feature_t'($random(seed)),
				feature_t'($random(seed)), 1'($random(seed)));
		end
		@(negedge clk);
		i_wen1 = 1'b0;

		start_walk();
		wait_for_done();
		check_pass(2);

		assert (ack_count == WALK_WORDS + 1)
			else begin
				error_count++;
				$display("Error at %0t: o_wb_ack count = %0d, expected %0d",
					$time, ack_count, WALK_WORDS + 1);
			end

		$display("Valid words: %0d, done pulses: %0d, acks: %0d, errors: %0d",
			word_count, done_count, ack_count, error_count);
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end
endmodule

/* files.f */
+incdir+source
source/fsb_data_pkg.sv
source/fsb_ctrl_pkg.sv
source/fsb_ifaces.sv
source/feature_write_port.sv
source/feature_bank_ram.sv
source/dual_bank_feature_buffer.sv
source/window_read_sequencer.sv
source/feature_stream_buffer.sv
sim/tb_feature_stream_buffer.sv

/* Bender.yml */
package:
  name: feature_stream_buffer

sources:
  - include_dirs:
      - source
    files:
      - source/fsb_data_pkg.sv
      - source/fsb_ctrl_pkg.sv
      - source/fsb_ifaces.sv
      - source/feature_write_port.sv
      - source/feature_bank_ram.sv
      - source/dual_bank_feature_buffer.sv
      - source/window_read_sequencer.sv
      - source/feature_stream_buffer.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/tb_feature_stream_buffer.sv
